// ==== test/traceMonitor_testdata.txt ====
# name(0-11) pc(12-19) code(21-28) expected text(30-48) then a bar
# illegal entries probe the funct3, funct7 and opcode fields
add         00001000 003100B3  add x01,x02,x03   |
sub         00001004 403100B3  sub x01,x02,x03   |
sll         00001008 003110B3  sll x01,x02,x03   |
slt         0000100C 003120B3  slt x01,x02,x03   |
sltu        00001010 003130B3  sltu x01,x02,x03  |
xor         00001014 003140B3  xor x01,x02,x03   |
srl         00001018 003150B3  srl x01,x02,x03   |
sra         0000101C 403150B3  sra x01,x02,x03   |
or          00001020 003160B3  or x01,x02,x03    |
and         00001024 003170B3  and x01,x02,x03   |
add_x1f     00001028 00A80FB3  add x1F,x10,x0A   |
addi        0000102C 12310093 addi x01,x02,123H  |
slli        00001030 12311093 slli x01,x02,123H  |
slti        00001034 12312093 slti x01,x02,123H  |
sltiu       00001038 12313093 sltiu x01,x02,123H |
xori        0000103C 12314093 xori x01,x02,123H  |
srli        00001040 12315093 srli x01,x02,123H  |
srai        00001044 40315093 srai x01,x02,403H  |
ori         00001048 12316093 ori x01,x02,123H   |
andi        0000104C 12317093 andi x01,x02,123H  |
lw          00001050 01032283  lw x05,x06,010H   |
sw          00001054 02742223  sw x08,x07,024H   |
jalr        00001058 004100E7 jalr x01,x02,004H  |
beq         0000105C 00208863 beq x01,x02,0010   |
bne         00001060 802090E3 bne x01,x02,1800   |
blt         00001064 0020C863 blt x01,x02,0010   |
bge         00001068 0020D863 bge x01,x02,0010   |
bltu        0000106C 0020E863 bltu x01,x02,0010  |
bgeu        00001070 0020F863 bgeu x01,x02,0010  |
jal         00001074 100000EF jal x01,000100H    |
lui         00001078 ABCDE1B7 lui x03,ABCDEH     |
nop_dstall  0000107C 00000000 nop DStall:lw 00   |
nop_jstall  00001080 00000013 nop JStall:addi0   |
ill_opcode  00001084 0000007F illegal instruction|
ill_funct3  00001088 0020A863 illegal instruction|
ill_funct7  0000108C 403110B3 illegal instruction|

// ==== all.f ====
hdl/traceMonitorPkg.sv
hdl/instDisassembler.sv
hdl/traceFifo.sv
hdl/monitorConfig.sv
hdl/textSerializer.sv
hdl/traceMonitorTop.sv
test/traceMonitor_properties.sv
test/traceMonitorTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module traceMonitorTb -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== test/traceMonitorTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module traceMonitorTb;
    localparam int fifoDepth = 8;

    logic        clk;
    logic        rst;
    logic        traceValid;
    logic [31:0] tracePc;
    logic [31:0] traceCode;
    logic        cfgWrite;
    logic        cfgAddr;
    logic [15:0] cfgWdata;
    logic [15:0] cfgRdata;
    logic        charValid;
    logic [7:0]  charData;

    string       names[$];
    logic [31:0] pcs[$];
    logic [31:0] codes[$];
    string       texts[$];
    string       expLines[$];
    string       expNames[$];
    string       lineBuf;

    traceMonitorTop #(
        .fifoDepth(fifoDepth)
    ) i_traceMonitorTop (
        .clk       (clk),
        .rst       (rst),
        .traceValid(traceValid),
        .tracePc   (tracePc),
        .traceCode (traceCode),
        .cfgWrite  (cfgWrite),
        .cfgAddr   (cfgAddr),
        .cfgWdata  (cfgWdata),
        .cfgRdata  (cfgRdata),
        .charValid (charValid),
        .charData  (charData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // 8 uppercase hex digits, space, text, newline.
    function automatic string formatLine(input logic [31:0] pc, input string text);
        string hex;
        logic [3:0] nib;
        hex = "00000000";
        for (int i = 0; i < 8; i++) begin
            nib = pc[(7 - i) * 4 +: 4];
            hex.putc(i, (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib});
        end
        return {hex, " ", text, "\n"};
    endfunction

    task automatic driveTrace(input logic valid, input logic [31:0] pc, input logic [31:0] code);
        @(posedge clk);
        #1;
        traceValid = valid;
        tracePc = pc;
        traceCode = code;
    endtask

    task automatic writeReg(input logic addr, input logic [15:0] data);
        @(posedge clk);
        #1;
        cfgWrite = 1'b1;
        cfgAddr = addr;
        cfgWdata = data;
        @(posedge clk);
        #1;
        cfgWrite = 1'b0;
    endtask

    task automatic checkReg(input string name, input logic addr, input logic [15:0] exp);
        @(posedge clk);
        #1;
        cfgAddr = addr;
        #1;
        assert (cfgRdata == exp) else
            stopWithError($sformatf("ERR %s expected %h actual %h", name, exp, cfgRdata));
    endtask

    task automatic waitDrain(input int limit);
        for (int i = 0; i < limit && expLines.size() > 0; i++) begin
            @(posedge clk);
        end
        if (expLines.size() > 0) begin
            stopWithError($sformatf("timeout with %0d lines still missing", expLines.size()));
        end
    endtask

    // collects the character stream into lines.
    always @(posedge clk) begin
        string ch;
        if (!rst && charValid) begin
            assert (expLines.size() > 0) else
                stopWithError("character sent while no line was expected");
            ch = " ";
            ch.putc(0, charData);
            lineBuf = {lineBuf, ch};
            if (charData == 8'h0A) begin
                assert (lineBuf == expLines[0]) else
                    stopWithError($sformatf("ERR %s expected %s actual %s", expNames[0],
                        expLines[0].substr(0, 27), lineBuf.substr(0, lineBuf.len() - 2)));
                void'(expLines.pop_front());
                void'(expNames.pop_front());
                lineBuf = "";
            end
        end
    end

    initial begin
        int fd;
        int fill;
        int nextPop;
        int kept;
        string line;
        rst = 1'b1;
        traceValid = 1'b0;
        tracePc = '0;
        traceCode = '0;
        cfgWrite = 1'b0;
        cfgAddr = 1'b0;
        cfgWdata = '0;
        lineBuf = "";
        void'($urandom(66));
        fd = $fopen("test/traceMonitor_testdata.txt", "r");
        if (fd == 0) begin
            stopWithError("cannot open test data file");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() >= 49 && line.getc(0) != "#") begin
                names.push_back(line.substr(0, 11));
                pcs.push_back(32'(line.substr(12, 19).atohex()));
                codes.push_back(32'(line.substr(21, 28).atohex()));
                texts.push_back(line.substr(30, 48));
            end
        end
        $fclose(fd);
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        // every entry with random gaps.
        foreach (codes[i]) begin
            expLines.push_back(formatLine(pcs[i], texts[i]));
            expNames.push_back(names[i]);
            driveTrace(1'b1, pcs[i], codes[i]);
            repeat (30 + $urandom_range(19, 0)) driveTrace(1'b0, '0, '0);
        end
        waitDrain(400 * codes.size());
        checkReg("drops_after_list", 1'b1, 16'd0);

        // burst into the FIFO, one pop per 32 cycles.
        fill = 0;
        nextPop = 1;
        kept = 0;
        for (int e = 1; e <= 12; e++) begin
            if (fill < fifoDepth) begin
                expLines.push_back(formatLine(32'h0000_2000 + 32'(e * 4), texts[e - 1]));
                expNames.push_back({"burst_", names[e - 1]});
                kept++;
                fill++;
            end
            if (e >= nextPop && fill > 1) begin
                fill--;
                nextPop = e + 32;
            end
            driveTrace(1'b1, 32'h0000_2000 + 32'(e * 4), codes[e - 1]);
        end
        driveTrace(1'b0, '0, '0);
        waitDrain(40 * 12);
        checkReg("drops_burst", 1'b1, 16'(12 - kept));

        // capture off.
        writeReg(1'b1, 16'hFFFF);
        writeReg(1'b0, 16'h0000);
        checkReg("control_off", 1'b0, 16'h0000);
        for (int i = 0; i < 3; i++) begin
            driveTrace(1'b1, 32'h0000_3000, codes[i]);
            driveTrace(1'b0, '0, '0);
        end
        repeat (40) @(posedge clk);
        checkReg("drops_disabled", 1'b1, 16'd3);

        // skip nops.
        writeReg(1'b1, 16'h0000);
        checkReg("drops_cleared", 1'b1, 16'd0);
        writeReg(1'b0, 16'h0003);
        checkReg("control_skip", 1'b0, 16'h0003);
        driveTrace(1'b1, 32'h0000_4000, 32'h0000_0000);
        driveTrace(1'b1, 32'h0000_4004, 32'h0000_0013);
        expLines.push_back(formatLine(32'h0000_4008, texts[0]));
        expNames.push_back("skip_keep");
        driveTrace(1'b1, 32'h0000_4008, codes[0]);
        driveTrace(1'b0, '0, '0);
        waitDrain(200);
        repeat (40) @(posedge clk);
        checkReg("drops_skip", 1'b1, 16'd0);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/traceMonitor_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module traceMonitorProps #(
    parameter int fifoDepth = 8
) (
    input logic clk,
    input logic rst,
    input logic popEn,
    input logic fifoEmpty,
    input logic charValid,
    input logic push,
    input logic full
);
    localparam int fillWidth = $clog2(fifoDepth + 1);
    localparam logic [fillWidth-1:0] fillMax = fillWidth'(fifoDepth);

    logic [5:0]           runLen;
    logic [fillWidth-1:0] fill;

    always_ff @(posedge clk) begin
        if (rst || !charValid) begin
            runLen <= '0;
        end else begin
            runLen <= runLen + 1'b1;    // cycles of the current line.
        end
    end

    // fill level seen from the push and pop strobes.
    always_ff @(posedge clk) begin
        if (rst) begin
            fill <= '0;
        end else if (push && !popEn) begin
            fill <= fill + 1'b1;
        end else if (popEn && !push) begin
            fill <= fill - 1'b1;
        end
    end

    lineLength: assert property (@(posedge clk) disable iff (rst)
        $fell(charValid) |-> runLen == 6'd29) else $error("line length wrong");
    lineNotTooLong: assert property (@(posedge clk) disable iff (rst)
        charValid |-> runLen < 6'd29) else $error("line longer than 29");
    popNotEmpty: assert property (@(posedge clk) disable iff (rst)
        popEn |-> fill != '0) else $error("pop from empty FIFO");
    pushNotFull: assert property (@(posedge clk) disable iff (rst)
        push |-> fill != fillMax) else $error("push into full FIFO");
    flagsMatchFill: assert property (@(posedge clk) disable iff (rst)
        (fifoEmpty == (fill == '0)) && (full == (fill == fillMax)))
        else $error("FIFO flags disagree with fill level");

endmodule

bind traceMonitorTop traceMonitorProps #(
    .fifoDepth(fifoDepth)
) i_traceMonitorProps (
    .clk      (clk),
    .rst      (rst),
    .popEn    (popEn),
    .fifoEmpty(fifoEmpty),
    .charValid(charValid),
    .push     (captureEn),
    .full     (fifoFull)
);

`default_nettype wire

// ==== hdl/traceMonitorTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module traceMonitorTop #(
    parameter int fifoDepth = 8,
    parameter int dropCountWidth = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        traceValid,
    input  logic [31:0] tracePc,
    input  logic [31:0] traceCode,
    input  logic        cfgWrite,
    input  logic        cfgAddr,
    input  logic [15:0] cfgWdata,
    output logic [15:0] cfgRdata,
    output logic        charValid,
    output logic [7:0]  charData
);
    import traceMonitorPkg::*;

    logic        captureEn;
    logic        fifoFull;
    logic        fifoEmpty;
    logic        popEn;
    logic        codeValid;
    logic [31:0] code;
    logic        textValid;

    traceEntry_t pushEntry;
    traceEntry_t popData;
    instText_t   instText;

    assign pushEntry = '{pc: tracePc, code: traceCode};

    monitorConfig #(
        .dropCountWidth(dropCountWidth)
    ) i_monitorConfig (
        .clk       (clk),
        .rst       (rst),
        .cfgWrite  (cfgWrite),
        .cfgAddr   (cfgAddr),
        .cfgWdata  (cfgWdata),
        .cfgRdata  (cfgRdata),
        .traceValid(traceValid),
        .traceCode (traceCode),
        .fifoFull  (fifoFull),
        .captureEn (captureEn)
    );

    traceFifo #(
        .depth    (fifoDepth),
        .payload_t(traceEntry_t)
    ) i_traceFifo (
        .clk     (clk),
        .rst     (rst),
        .push    (captureEn),
        .pushData(pushEntry),
        .pop     (popEn),
        .popData (popData),
        .full    (fifoFull),
        .empty   (fifoEmpty)
    );

    instDisassembler i_instDisassembler (
        .clk      (clk),
        .rst      (rst),
        .codeValid(codeValid),
        .code     (code),
        .textValid(textValid),
        .instText (instText)
    );

    textSerializer i_textSerializer (
        .clk      (clk),
        .rst      (rst),
        .fifoEmpty(fifoEmpty),
        .popEn    (popEn),
        .popData  (popData),
        .codeValid(codeValid),
        .code     (code),
        .textValid(textValid),
        .instText (instText),
        .charValid(charValid),
        .charData (charData)
    );

endmodule

`default_nettype wire

// ==== hdl/textSerializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module textSerializer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       fifoEmpty,
    output logic                       popEn,
    input  traceMonitorPkg::traceEntry_t popData,
    output logic                       codeValid,
    output logic [31:0]                code,
    input  logic                       textValid,
    input  traceMonitorPkg::instText_t instText,
    output logic                       charValid,
    output logic [7:0]                 charData
);
    import traceMonitorPkg::*;

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stDecode,
        stSend
    } state_t;

    localparam int pcChars = 8;
    localparam int textStart = pcChars + 1;
    localparam logic [4:0] lastIdx = 5'(lineChars - 1);

    state_t      state;
    logic [4:0]  charIdx;
    logic [31:0] pcLatched;
    instText_t   lineText;

    assign popEn = (state == stIdle) && !fifoEmpty;
    assign codeValid = (state == stFetch);   // popData is valid here.
    assign code = popData.code;
    assign charValid = (state == stSend);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            charIdx <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (!fifoEmpty) begin
                        state <= stFetch;
                    end
                end
                stFetch: state <= stDecode;
                stDecode: begin
                    if (textValid) begin
                        charIdx <= '0;
                        state <= stSend;
                    end
                end
                default: begin
                    if (charIdx == lastIdx) begin
                        state <= stIdle;     // next pop right after the newline.
                    end else begin
                        charIdx <= charIdx + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetch) begin
            pcLatched <= popData.pc;
        end
        if (state == stDecode && textValid) begin
            lineText <= instText;
        end
    end

    always_comb begin
        charData = asciiNewline;
        if (int'(charIdx) < pcChars) begin
            charData = hexChar(pcLatched[(pcChars - 1 - int'(charIdx)) * 4 +: 4]);
        end else if (int'(charIdx) == pcChars) begin
            charData = asciiSpace;
        end else if (charIdx < lastIdx) begin
            // text bytes go out top byte first.
            charData = lineText[(instTextChars - 1 - (int'(charIdx) - textStart)) * 8 +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/monitorConfig.sv ====
`timescale 1ns/1ns
`default_nettype none

module monitorConfig #(
    parameter int dropCountWidth = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        cfgWrite,
    input  logic        cfgAddr,
    input  logic [15:0] cfgWdata,
    output logic [15:0] cfgRdata,
    input  logic        traceValid,
    input  logic [31:0] traceCode,
    input  logic        fifoFull,
    output logic        captureEn
);
    import traceMonitorPkg::*;

    logic                      enable;
    logic                      skipNop;
    logic [dropCountWidth-1:0] dropCount;
    logic                      isNop;
    logic                      wanted;
    logic                      drop;

    assign isNop = (traceCode == 32'h0000_0000) || (traceCode == 32'h0000_0013);
    assign wanted = traceValid && !(skipNop && isNop);   // skipped nops are not drops.
    assign captureEn = wanted && enable && !fifoFull;
    assign drop = wanted && (!enable || fifoFull);

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b1;
            skipNop <= 1'b0;
            dropCount <= '0;
        end else begin
            if (cfgWrite && cfgAddr == cfgAddrControl) begin
                enable <= cfgWdata[0];
                skipNop <= cfgWdata[1];
            end
            if (cfgWrite && cfgAddr == cfgAddrDrops) begin
                dropCount <= '0;                         // clear beats a drop.
            end else if (drop && dropCount != '1) begin
                dropCount <= dropCount + 1'b1;           // saturates.
            end
        end
    end

    assign cfgRdata = (cfgAddr == cfgAddrDrops) ? 16'(dropCount) : {14'b0, skipNop, enable};

endmodule

`default_nettype wire

// ==== hdl/traceFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module traceFifo #(
    parameter int  depth = 8,
    parameter type payload_t = logic [63:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t pushData,
    input  logic     pop,
    output payload_t popData,
    output logic     full,
    output logic     empty
);
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);
    localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(depth - 1);

    payload_t mem [depth];

    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [countWidth-1:0] count;
    logic                  pushOk;
    logic                  popOk;

    assign full = (count == countWidth'(depth));
    assign empty = (count == '0);
    assign pushOk = push && !full;    // push into a full buffer is lost.
    assign popOk = pop && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushOk) begin
                wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (popOk) begin
                rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;
            end
            if (pushOk && !popOk) begin
                count <= count + 1'b1;
            end else if (popOk && !pushOk) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pushOk) begin
            mem[wrPtr] <= pushData;
        end
        if (popOk) begin
            popData <= mem[rdPtr];    // valid the cycle after pop.
        end
    end

endmodule

`default_nettype wire

// ==== hdl/instDisassembler.sv ====
`timescale 1ns/1ns
`default_nettype none

module instDisassembler (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     codeValid,
    input  logic [31:0]              code,
    output logic                     textValid,
    output traceMonitorPkg::instText_t instText
);
    import traceMonitorPkg::*;

    localparam instText_t illegalText = "illegal instruction";

    logic [23:0] rdText;
    logic [23:0] rs1Text;
    logic [23:0] rs2Text;
    logic [23:0] immText;
    logic [23:0] sImmText;
    logic [31:0] sbImmText;
    logic [47:0] ujImmText;
    logic [39:0] uImmText;

    logic [103:0] rOperands;
    logic [103:0] iOperands;
    logic [103:0] sOperands;
    logic [103:0] sbOperands;
    logic [103:0] ujOperands;
    logic [103:0] uOperands;

    instText_t decodedText;

    // registers print as x00..x1F.
    assign rdText = {"x", hexChar({3'b000, code[11]}), hexChar(code[10:7])};
    assign rs1Text = {"x", hexChar({3'b000, code[19]}), hexChar(code[18:15])};
    assign rs2Text = {"x", hexChar({3'b000, code[24]}), hexChar(code[23:20])};

    assign immText = {hexChar(code[31:28]), hexChar(code[27:24]), hexChar(code[23:20])};
    assign sImmText = {hexChar(code[31:28]), hexChar({code[27:25], code[11]}),
                       hexChar(code[10:7])};
    // branch and jump offsets keep their implied zero lsb.
    assign sbImmText = {hexChar({3'b000, code[31]}), hexChar({code[7], code[30:28]}),
                        hexChar({code[27:25], code[11]}), hexChar({code[10:8], 1'b0})};
    assign ujImmText = {hexChar({3'b000, code[31]}), hexChar(code[19:16]),
                        hexChar(code[15:12]), hexChar({code[20], code[30:28]}),
                        hexChar(code[27:24]), hexChar({code[23:21], 1'b0})};
    assign uImmText = {hexChar(code[31:28]), hexChar(code[27:24]), hexChar(code[23:20]),
                       hexChar(code[19:16]), hexChar(code[15:12])};

    // every operand field is 13 characters wide.
    assign rOperands = {" ", rdText, ",", rs1Text, ",", rs2Text, " "};
    assign iOperands = {" ", rdText, ",", rs1Text, ",", immText, "H"};
    assign sOperands = {" ", rs1Text, ",", rs2Text, ",", sImmText, "H"};
    assign sbOperands = {" ", rs1Text, ",", rs2Text, ",", sbImmText};
    assign ujOperands = {" ", rdText, ",", ujImmText, "H "};
    assign uOperands = {" ", rdText, ",", uImmText, "H  "};

    always_comb begin
        decodedText = illegalText;
        if (code == 32'h0000_0000) begin
            decodedText = "nop DStall:lw 00   ";
        end else if (code == 32'h0000_0013) begin
            decodedText = "nop JStall:addi0   ";
        end else if (code[1:0] == 2'b11) begin       // compressed codes stay illegal.
            case (code[6:2])
                5'b01100: begin
                    // only bit 30 of funct7 may be set, M codes stay illegal.
                    if ({code[31], code[29:25]} == 6'b000000) begin
                        case ({code[14:12], code[30]})
                            4'b0000: decodedText = {" add", rOperands, "  "};
                            4'b0001: decodedText = {" sub", rOperands, "  "};
                            4'b1110: decodedText = {" and", rOperands, "  "};
                            4'b1100: decodedText = {" or", rOperands, "   "};
                            4'b0100: decodedText = {" slt", rOperands, "  "};
                            4'b0110: decodedText = {" sltu", rOperands, " "};
                            4'b1010: decodedText = {" srl", rOperands, "  "};
                            4'b1011: decodedText = {" sra", rOperands, "  "};
                            4'b1000: decodedText = {" xor", rOperands, "  "};
                            4'b0010: decodedText = {" sll", rOperands, "  "};
                            default: decodedText = illegalText;
                        endcase
                    end
                end
                5'b00000: decodedText = {" lw", iOperands, "   "};
                5'b01000: decodedText = {" sw", sOperands, "   "};
                5'b11000: begin
                    case (code[14:12])
                        3'b000: decodedText = {"beq", sbOperands, "   "};
                        3'b001: decodedText = {"bne", sbOperands, "   "};
                        3'b100: decodedText = {"blt", sbOperands, "   "};
                        3'b110: decodedText = {"bltu", sbOperands, "  "};
                        3'b101: decodedText = {"bge", sbOperands, "   "};
                        3'b111: decodedText = {"bgeu", sbOperands, "  "};
                        default: decodedText = illegalText;
                    endcase
                end
                5'b11011: decodedText = {"jal", ujOperands, "   "};
                5'b11001: decodedText = {"jalr", iOperands, "  "};
                5'b00100: begin
                    case (code[14:12])
                        3'b000: decodedText = {"addi", iOperands, "  "};
                        3'b111: decodedText = {"andi", iOperands, "  "};
                        3'b110: decodedText = {"ori", iOperands, "   "};
                        3'b010: decodedText = {"slti", iOperands, "  "};
                        3'b011: decodedText = {"sltiu", iOperands, " "};
                        3'b101: begin
                            if (code[30]) begin
                                decodedText = {"srai", iOperands, "  "};
                            end else begin
                                decodedText = {"srli", iOperands, "  "};
                            end
                        end
                        3'b001: decodedText = {"slli", iOperands, "  "};
                        default: decodedText = {"xori", iOperands, "  "};
                    endcase
                end
                5'b01101: decodedText = {"lui", uOperands, "   "};
                default: decodedText = illegalText;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            textValid <= 1'b0;
        end else begin
            textValid <= codeValid;
        end
    end

    // text holds until the next request.
    always_ff @(posedge clk) begin
        if (codeValid) begin
            instText <= decodedText;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/traceMonitorPkg.sv ====
`default_nettype none

package traceMonitorPkg;

    // one retired instruction as reported by the core.
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] code;
    } traceEntry_t;

    localparam int instTextChars = 19;
    localparam int lineChars = 29;     // 8 pc digits, space, text, newline.

    // first character in the top byte.
    typedef logic [instTextChars*8-1:0] instText_t;

    localparam logic cfgAddrControl = 1'b0;
    localparam logic cfgAddrDrops = 1'b1;

    localparam logic [7:0] asciiSpace = 8'h20;
    localparam logic [7:0] asciiNewline = 8'h0A;

    function automatic logic [7:0] hexChar(input logic [3:0] nibble);
        logic [7:0] wide;
        wide = {4'b0000, nibble};
        if (nibble < 4'd10) begin
            return 8'h30 + wide;       // '0'..'9'.
        end
        return 8'h37 + wide;           // 'A'..'F'.
    endfunction

endpackage

`default_nettype wire
